/* include/cdb_defs.svh */
`ifndef CDB_DEFS_SVH
`define CDB_DEFS_SVH

// result path sizing

`define CDB_FU_COUNT 4          // alu0, alu1, lsu, mdu
`define CDB_LANE_COUNT 2        // broadcasts per cycle

// physical register file
`define CDB_PREG_COUNT 64
`define CDB_PREG_WIDTH 6

`define CDB_WORD_WIDTH 32       // result data

// per-unit result buffering
`define CDB_RESULT_FIFO_DEPTH 2

`endif

/* hdl/cdb_pkg.sv */
`include "cdb_defs.svh"

package cdb_pkg;

    // one result word
    typedef logic [`CDB_WORD_WIDTH-1:0] word_t;

    typedef logic [`CDB_PREG_WIDTH-1:0] preg_id_t; // physical register number

    // unit index, wraps naturally over the unit count
    typedef logic [$clog2(`CDB_FU_COUNT)-1:0] fu_idx_t;

    // what a unit hands to the CDB and what a lane carries
    typedef struct packed {
        preg_id_t rob_id;   // destination tag
        word_t    w_data;
        logic     w_reg;    // result writes a register
    } cdb_info_t;

endpackage

/* hdl/result_fifo.sv */
`timescale 1ns/10ps
`include "cdb_defs.svh"

module result_fifo #(
    parameter int DEPTH = `CDB_RESULT_FIFO_DEPTH
) (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               flush_i,
    input  logic               push_valid_i,
    input  cdb_pkg::cdb_info_t push_data_i,
    output logic               push_ready_o,
    input  logic               pop_i,
    output logic               head_valid_o,
    output cdb_pkg::cdb_info_t head_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    cdb_pkg::cdb_info_t mem [DEPTH];
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W-1:0]   wr_ptr;
    logic [CNT_W-1:0]   count;
    logic               push_fire;

    // circular increment, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        ptr_inc = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push_ready_o = (count != CNT_W'(DEPTH)); // low only when full
    assign push_fire    = push_valid_i && push_ready_o;
    assign head_valid_o = (count != '0);
    assign head_o       = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop_i) begin
                rd_ptr <= ptr_inc(rd_ptr); // arbiter only pops a valid head
            end
            case ({push_fire, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // none, or push and pop together
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (push_fire) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

endmodule

/* hdl/cdb_arbiter.sv */
`timescale 1ns/10ps
`include "cdb_defs.svh"

module cdb_arbiter (
    input  logic                                      clk,
    input  logic                                      rst_i,
    input  logic                                      flush_i,
    input  logic [`CDB_FU_COUNT-1:0]                  head_valid_i,
    input  cdb_pkg::cdb_info_t [`CDB_FU_COUNT-1:0]    head_i,
    output logic [`CDB_FU_COUNT-1:0]                  pop_o,
    output logic [`CDB_LANE_COUNT-1:0]                cdb_valid_o,
    output cdb_pkg::cdb_info_t [`CDB_LANE_COUNT-1:0]  cdb_o
);

    cdb_pkg::fu_idx_t rr_ptr;   // first unit considered this cycle
    cdb_pkg::fu_idx_t ptr_nxt;
    cdb_pkg::fu_idx_t cand;
    int               grant_cnt; // lanes filled so far

    logic [`CDB_LANE_COUNT-1:0]               lane_valid;
    cdb_pkg::cdb_info_t [`CDB_LANE_COUNT-1:0] lane_data;

    // walk the units from the pointer, wrapping, and fill lanes in order
    always_comb begin
        pop_o      = '0;
        lane_valid = '0;
        lane_data  = '0;
        grant_cnt  = 0;
        ptr_nxt    = rr_ptr; // pointer stays when nothing granted
        cand       = rr_ptr;
        for (int k = 0; k < `CDB_FU_COUNT; k++) begin
            cand = rr_ptr + cdb_pkg::fu_idx_t'(k); // wraps in the index width
            if (head_valid_i[cand] && (grant_cnt < `CDB_LANE_COUNT)) begin
                pop_o[cand]           = 1'b1;
                lane_valid[grant_cnt] = 1'b1;  // lane 0 always taken first
                lane_data[grant_cnt]  = head_i[cand];
                grant_cnt             = grant_cnt + 1;
                ptr_nxt               = cand + 1'b1; // one past last grant
            end
        end
    end

    // control state
    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            rr_ptr      <= '0;
            cdb_valid_o <= '0; // flushed results never reach the bus
        end else begin
            rr_ptr      <= ptr_nxt;
            cdb_valid_o <= lane_valid;
        end
    end

    // lane payload
    always_ff @(posedge clk) begin
        cdb_o <= lane_data;
    end

endmodule

/* hdl/preg_ready_table.sv */
`timescale 1ns/10ps
`include "cdb_defs.svh"

module preg_ready_table #(
    parameter int QUERY_COUNT = 2
) (
    input  logic                                      clk,
    input  logic                                      rst_i,
    input  logic                                      flush_i,
    input  logic                                      alloc_valid_i,
    input  cdb_pkg::preg_id_t                         alloc_preg_i,
    input  logic [`CDB_LANE_COUNT-1:0]                cdb_valid_i,
    input  cdb_pkg::cdb_info_t [`CDB_LANE_COUNT-1:0]  cdb_i,
    input  cdb_pkg::preg_id_t [QUERY_COUNT-1:0]       query_preg_i,
    output logic [QUERY_COUNT-1:0]                    query_ready_o
);

    logic [`CDB_PREG_COUNT-1:0] busy_q; // one bit per physical register
    logic [`CDB_PREG_COUNT-1:0] busy_d;

    always_comb begin
        busy_d = busy_q;
        // wakeup from the bus
        for (int l = 0; l < `CDB_LANE_COUNT; l++) begin
            if (cdb_valid_i[l] && cdb_i[l].w_reg) begin
                busy_d[cdb_i[l].rob_id] = 1'b0;
            end
        end
        // applied last so a same-cycle collision leaves it busy
        if (alloc_valid_i) begin
            busy_d[alloc_preg_i] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            busy_q <= '0; // everything ready
        end else begin
            busy_q <= busy_d;
        end
    end

    // zero-cycle read of the stored bits
    always_comb begin
        for (int q = 0; q < QUERY_COUNT; q++) begin
            query_ready_o[q] = ~busy_q[query_preg_i[q]];
        end
    end

endmodule

/* hdl/cdb_top.sv */
`timescale 1ns/10ps
`include "cdb_defs.svh"

module cdb_top (
    input  logic                                      clk,
    input  logic                                      rst_i,
    input  logic                                      flush_i,
    input  logic [`CDB_FU_COUNT-1:0]                  fu_valid_i,
    input  cdb_pkg::cdb_info_t [`CDB_FU_COUNT-1:0]    fu_result_i,
    output logic [`CDB_FU_COUNT-1:0]                  fu_ready_o,
    output logic [`CDB_LANE_COUNT-1:0]                cdb_valid_o,
    output cdb_pkg::cdb_info_t [`CDB_LANE_COUNT-1:0]  cdb_o,
    input  logic                                      alloc_valid_i,
    input  cdb_pkg::preg_id_t                         alloc_preg_i,
    input  cdb_pkg::preg_id_t [1:0]                   query_preg_i,
    output logic [1:0]                                query_ready_o
);

    localparam int QUERY_COUNT = 2; // dispatch source operand ports

    logic [`CDB_FU_COUNT-1:0]               head_valid;
    cdb_pkg::cdb_info_t [`CDB_FU_COUNT-1:0] head;
    logic [`CDB_FU_COUNT-1:0]               pop;

    // one result buffer per unit: alu0, alu1, lsu, mdu
    for (genvar i = 0; i < `CDB_FU_COUNT; i++) begin : g_fu_fifo
        result_fifo u_result_fifo (
            .clk          (clk),
            .rst_i        (rst_i),
            .flush_i      (flush_i),
            .push_valid_i (fu_valid_i[i]),
            .push_data_i  (fu_result_i[i]),
            .push_ready_o (fu_ready_o[i]),
            .pop_i        (pop[i]),
            .head_valid_o (head_valid[i]),
            .head_o       (head[i])
        );
    end

    cdb_arbiter u_cdb_arbiter (
        .clk          (clk),
        .rst_i        (rst_i),
        .flush_i      (flush_i),
        .head_valid_i (head_valid),
        .head_i       (head),
        .pop_o        (pop),
        .cdb_valid_o  (cdb_valid_o),
        .cdb_o        (cdb_o)
    );

    // wakeup straight from the registered lanes
    preg_ready_table #(
        .QUERY_COUNT (QUERY_COUNT)
    ) u_preg_ready_table (
        .clk           (clk),
        .rst_i         (rst_i),
        .flush_i       (flush_i),
        .alloc_valid_i (alloc_valid_i),
        .alloc_preg_i  (alloc_preg_i),
        .cdb_valid_i   (cdb_valid_o),
        .cdb_i         (cdb_o),
        .query_preg_i  (query_preg_i),
        .query_ready_o (query_ready_o)
    );

endmodule

/* bench/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // released right after the last reset edge
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

/* bench/tb_cdb_top.sv */
`timescale 1ns/10ps
`include "cdb_defs.svh"

module tb_cdb_top;

    localparam int STIM_CYCLES    = 2000;
    localparam int TIMEOUT_CYCLES = 3 * STIM_CYCLES + 100;
    localparam int DEPTH          = `CDB_RESULT_FIFO_DEPTH;

    logic clk;
    logic rst;
    logic flush;
    logic [`CDB_FU_COUNT-1:0]                  fu_valid;
    cdb_pkg::cdb_info_t [`CDB_FU_COUNT-1:0]    fu_result;
    logic [`CDB_FU_COUNT-1:0]                  fu_ready;
    logic [`CDB_LANE_COUNT-1:0]                cdb_valid;
    cdb_pkg::cdb_info_t [`CDB_LANE_COUNT-1:0]  cdb_res;
    logic                                      alloc_valid;
    cdb_pkg::preg_id_t                         alloc_preg;
    cdb_pkg::preg_id_t [1:0]                   query_preg;
    logic [1:0]                                query_ready;

    // reference model
    cdb_pkg::cdb_info_t         exp_q [`CDB_FU_COUNT][$]; // accepted, not yet broadcast
    logic [`CDB_PREG_COUNT-1:0] busy_model;
    logic [`CDB_FU_COUNT-1:0]   holding;     // unit keeps its result on the port
    logic [13:0]                seq [`CDB_FU_COUNT];
    logic                       flush_done;  // flush hit the last edge
    logic [31:0]                lfsr = 32'h4f52_2a74;
    int                         cycle = 0;
    int                         value_errs = 0;
    int                         other_errs = 0;

    tb_clock_gen u_clock_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    cdb_top u_dut (
        .clk           (clk),
        .rst_i         (rst),
        .flush_i       (flush),
        .fu_valid_i    (fu_valid),
        .fu_result_i   (fu_result),
        .fu_ready_o    (fu_ready),
        .cdb_valid_o   (cdb_valid),
        .cdb_o         (cdb_res),
        .alloc_valid_i (alloc_valid),
        .alloc_preg_i  (alloc_preg),
        .query_preg_i  (query_preg),
        .query_ready_o (query_ready)
    );

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    task automatic check_outputs();
        cdb_pkg::cdb_info_t exp_res;
        int                 unit;
        if (flush_done) begin
            assert (cdb_valid == '0) else begin
                $display("Error: cdb_valid_o after flush expected %h got %h", 2'h0, cdb_valid);
                value_errs++;
            end
        end
        assert (!(cdb_valid[1] && !cdb_valid[0])) else begin
            $display("lane 1 carried a result while lane 0 was idle at cycle %0d", cycle);
            other_errs++;
        end
        for (int l = 0; l < `CDB_LANE_COUNT; l++) begin
            if (cdb_valid[l]) begin
                unit = int'(cdb_res[l].w_data[31:30]); // unit tag in the top data bits
                assert (exp_q[unit].size() > 0) else begin
                    $display("unit %0d result on lane %0d with nothing outstanding at cycle %0d",
                             unit, l, cycle);
                    other_errs++;
                end
                if (exp_q[unit].size() > 0) begin
                    exp_res = exp_q[unit].pop_front();
                    assert (cdb_res[l] == exp_res) else begin
                        $display("Error: cdb_o[%0d] expected %h got %h", l, exp_res, cdb_res[l]);
                        value_errs++;
                    end
                end
            end
        end
        for (int n = 0; n < `CDB_FU_COUNT; n++) begin
            assert (exp_q[n].size() <= DEPTH) else begin
                $display("unit %0d has %0d results waiting, more than the fifo holds",
                         n, exp_q[n].size());
                other_errs++;
            end
            assert (fu_ready[n] == (exp_q[n].size() < DEPTH)) else begin
                $display("Error: fu_ready_o[%0d] expected %h got %h",
                         n, exp_q[n].size() < DEPTH, fu_ready[n]);
                value_errs++;
            end
        end
        for (int q = 0; q < 2; q++) begin
            assert (query_ready[q] == !busy_model[query_preg[q]]) else begin
                $display("Error: query_ready_o[%0d] preg %h expected %h got %h",
                         q, query_preg[q], !busy_model[query_preg[q]], query_ready[q]);
                value_errs++;
            end
        end
    endtask

    task automatic drive_inputs(input bit pushing);
        logic new_valid;
        flush = (lfsr_bits(7) == 0) && pushing;
        for (int n = 0; n < `CDB_FU_COUNT; n++) begin
            if (!holding[n]) begin
                if (!pushing) begin
                    new_valid = 1'b0;
                end else if (cycle[6]) begin
                    new_valid = (lfsr_bits(3) != 0); // burst, more than two lanes can take
                end else begin
                    new_valid = (lfsr_bits(2) == 0);
                end
                fu_valid[n] = new_valid;
                if (new_valid) begin
                    fu_result[n].rob_id = 6'(lfsr_bits(6));
                    fu_result[n].w_reg  = 1'(lfsr_bits(1));
                    fu_result[n].w_data = {2'(n), seq[n], 16'(lfsr_bits(16))};
                    seq[n] = seq[n] + 1'b1;
                end
            end
        end
        alloc_valid = 1'(lfsr_bits(1));
        if ((lfsr_bits(1) != 0) && cdb_valid[0]) begin
            alloc_preg = cdb_res[0].rob_id; // aim at a wakeup in the same cycle
        end else begin
            alloc_preg = 6'(lfsr_bits(6));
        end
        query_preg[0] = 6'(lfsr_bits(6));
        query_preg[1] = 6'(lfsr_bits(6));
    endtask

    // what the next rising edge does to the model
    task automatic predict_edge();
        logic accepted;
        if (flush) begin
            for (int n = 0; n < `CDB_FU_COUNT; n++) begin
                exp_q[n].delete();
            end
            busy_model = '0;
            holding    = '0;
        end else begin
            for (int l = 0; l < `CDB_LANE_COUNT; l++) begin
                if (cdb_valid[l] && cdb_res[l].w_reg) begin
                    busy_model[cdb_res[l].rob_id] = 1'b0;
                end
            end
            if (alloc_valid) begin
                busy_model[alloc_preg] = 1'b1; // allocation wins
            end
            for (int n = 0; n < `CDB_FU_COUNT; n++) begin
                accepted = fu_valid[n] && fu_ready[n];
                if (accepted) begin
                    exp_q[n].push_back(fu_result[n]);
                end
                holding[n] = fu_valid[n] && !accepted;
            end
        end
        flush_done = flush;
    endtask

    task automatic step_cycle(input bit pushing);
        @(negedge clk);
        check_outputs();
        drive_inputs(pushing);
        predict_edge();
    endtask

    function automatic bit work_left();
        bit left;
        left = (holding != '0) || (cdb_valid != '0);
        for (int n = 0; n < `CDB_FU_COUNT; n++) begin
            left = left || (exp_q[n].size() > 0);
        end
        return left;
    endfunction

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        flush       = 1'b0;
        fu_valid    = '0;
        fu_result   = '0;
        alloc_valid = 1'b0;
        alloc_preg  = '0;
        query_preg  = '0;
        holding     = '0;
        busy_model  = '0;
        flush_done  = 1'b0;
        for (int n = 0; n < `CDB_FU_COUNT; n++) begin
            seq[n] = '0;
        end
        wait (!rst);
        @(negedge clk);
        assert (cdb_valid == '0) else begin
            $display("Error: cdb_valid_o after reset expected %h got %h", 2'h0, cdb_valid);
            value_errs++;
        end
        assert (fu_ready == '1) else begin
            $display("Error: fu_ready_o after reset expected %h got %h", 4'hf, fu_ready);
            value_errs++;
        end
        // sweep every register, two per cycle
        for (int r = 0; r < `CDB_PREG_COUNT / 2; r++) begin
            @(negedge clk);
            query_preg[0] = 6'(2 * r);
            query_preg[1] = 6'(2 * r + 1);
            #1;
            assert (query_ready == 2'b11) else begin
                $display("Error: query_ready_o after reset preg %h expected %h got %h",
                         query_preg[0], 2'b11, query_ready);
                value_errs++;
            end
        end
        for (int c = 0; c < STIM_CYCLES; c++) begin
            step_cycle(1'b1);
        end
        while (work_left()) begin
            step_cycle(1'b0);
        end
        repeat (4) step_cycle(1'b0); // nothing may show up once drained
        $display("errors: value=%0d other=%0d", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+include
hdl/cdb_pkg.sv
hdl/result_fifo.sv
hdl/cdb_arbiter.sv
hdl/preg_ready_table.sv
hdl/cdb_top.sv
bench/tb_clock_gen.sv
bench/tb_cdb_top.sv

/* Makefile */
# Verilator flow for the CDB result path

VERILATOR ?= verilator
FILELIST  ?= filelist.f
TB_TOP    ?= tb_cdb_top
RTL_TOP   ?= cdb_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= STATUS: FAIL
PASS_MSG  ?= STATUS: PASS

SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)
SOURCES := $(wildcard hdl/*.sv bench/*.sv include/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "no status line in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
